// ==== run_sim.sh ====
#!/bin/sh
# Builds the store subsystem testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module store_subsystem_tb \
    -f store_subsystem.f \
    -o store_subsystem_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/store_subsystem_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0

// ==== source/data_memory_ctrl.sv ====
`timescale 1ns/1ps

`include "store_macros.svh"

module data_memory_ctrl import store_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_n_i,
    mem_write_if.responder   mem,
    input  logic [`XLEN-1:0] rd_address_i,
    output logic [`XLEN-1:0] rd_data_o
);

    localparam int WORDS = `MEM_BYTES / 4;
    localparam int IDX_W = $clog2(WORDS);
    localparam int CNT_W = $clog2(`UNCACHED_LATENCY + 1);

    logic [`XLEN-1:0] mem_array [WORDS];
    logic             busy_crt;
    logic [CNT_W-1:0] count_crt;
    logic [CNT_W-1:0] latency;
    logic [3:0]       byte_enable;
    logic [`XLEN-1:0] lane_data;
    logic [IDX_W-1:0] wr_index;

    //**************************************************************************
    // Latency counter
    //**************************************************************************

    always_comb begin
        if (mem.bufferable) begin
            latency = CNT_W'(`BUFFERED_LATENCY - 1);
        end else if (mem.cachable) begin
            latency = CNT_W'(`CACHED_LATENCY - 1);
        end else begin
            latency = CNT_W'(`UNCACHED_LATENCY - 1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_crt  <= 1'b0;
            count_crt <= '0;
        end else if (!busy_crt) begin
            if (mem.write) begin
                busy_crt  <= 1'b1;                // New request seen.
                count_crt <= latency;
            end
        end else if (count_crt == '0) begin
            busy_crt <= 1'b0;
        end else begin
            count_crt <= count_crt - 1'b1;
        end
    end

    assign mem.store_done = busy_crt && (count_crt == '0);

    //**************************************************************************
    // Byte lanes and storage
    //**************************************************************************

    always_comb begin
        case (mem.width)
            BYTE: begin
                byte_enable = 4'b0001 << mem.address[1:0];
                lane_data   = {4{mem.data[7:0]}};
            end
            HALF_WORD: begin
                byte_enable = 4'b0011 << {mem.address[1], 1'b0};
                lane_data   = {2{mem.data[15:0]}};
            end
            default: begin
                byte_enable = 4'b1111;
                lane_data   = mem.data;
            end
        endcase
    end

    assign wr_index = mem.address[IDX_W+1:2];

    always_ff @(posedge clk_i) begin
        if (mem.store_done) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byte_enable[lane]) begin
                    mem_array[wr_index][lane*8 +: 8] <= lane_data[lane*8 +: 8];
                end
            end
        end
    end

    assign rd_data_o = mem_array[rd_address_i[IDX_W+1:2]];   // Word aligned read.

    a_done_with_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem.store_done |-> mem.write);

endmodule : data_memory_ctrl

// ==== source/mem_write_if.sv ====
`timescale 1ns/1ps

`include "store_macros.svh"

interface mem_write_if import store_pkg::*; ();
    logic [`XLEN-1:0] address;
    logic [`XLEN-1:0] data;
    mem_width_t       width;
    logic             cachable;
    logic             bufferable;
    logic             write;                    // Held high until store_done.
    logic             store_done;               // One cycle pulse per write.

    modport requester (
        output address, data, width, cachable, bufferable, write,
        input  store_done
    );

    modport responder (
        input  address, data, width, cachable, bufferable, write,
        output store_done
    );
endinterface : mem_write_if

// ==== source/memory_region_decoder.sv ====
`timescale 1ns/1ps

`include "store_macros.svh"

module memory_region_decoder (
    input  logic [`XLEN-1:0] address_i,
    output logic             cachable_o,
    output logic             bufferable_o,
    output logic             writable_o
);

    logic boot_hit;
    logic int_table_hit;
    logic code_hit;
    logic mapped;

    function automatic logic in_region(input logic [`XLEN-1:0] addr,
                                       input logic [`XLEN-1:0] lo,
                                       input logic [`XLEN-1:0] hi);
        return (addr >= lo) && (addr <= hi);
    endfunction

    assign boot_hit      = in_region(address_i, `BOOT_REGION_START, `BOOT_REGION_END);
    assign int_table_hit = in_region(address_i, `INT_TABLE_REGION_START,
                                     `INT_TABLE_REGION_END);
    assign code_hit      = in_region(address_i, `CODE_REGION_START, `CODE_REGION_END);
    assign mapped        = (address_i <= `IO_REGION_END);      // IO is the top region.

    assign cachable_o   = int_table_hit | code_hit;
    assign bufferable_o = code_hit;
    assign writable_o   = mapped && !boot_hit;   // Boot is read only.

endmodule : memory_region_decoder

// ==== source/store_macros.svh ====
`ifndef STORE_MACROS_SVH
`define STORE_MACROS_SVH

`define XLEN 32
`define MEM_BYTES 1024

// Memory map, all bounds inclusive.
`define BOOT_REGION_START      32'h0000_0000
`define BOOT_REGION_END        32'h0000_00FF
`define INT_TABLE_REGION_START 32'h0000_0100
`define INT_TABLE_REGION_END   32'h0000_013F
`define CODE_REGION_START      32'h0000_0140
`define CODE_REGION_END        32'h0000_02FF
`define IO_REGION_START        32'h0000_0300
`define IO_REGION_END          32'h0000_03FF

// Cycles from write request to store_done.
`define BUFFERED_LATENCY 1
`define CACHED_LATENCY   2
`define UNCACHED_LATENCY 4

`endif

// ==== source/store_pkg.sv ====
package store_pkg;

    //**************************************************************************
    // Core side opcodes and memory access widths
    //**************************************************************************

    typedef enum logic [1:0] {
        SB,                                     // Store byte.
        SH,                                     // Store halfword.
        SW                                      // Store word.
    } store_op_t;

    typedef enum logic [1:0] {
        BYTE,
        HALF_WORD,
        WORD
    } mem_width_t;

    //**************************************************************************
    // Exceptions and the instruction packet
    //**************************************************************************

    typedef enum logic [3:0] {
        NO_EXCEPTION          = 4'd0,
        ILLEGAL_MEMORY_ACCESS = 4'd7            // Store access fault code.
    } exc_vector_t;

    typedef logic [3:0] tag_t;

    typedef struct packed {
        tag_t        tag;
        logic        exception;
        exc_vector_t exception_vector;
    } instr_packet_t;

endpackage : store_pkg

// ==== source/store_subsystem.sv ====
`timescale 1ns/1ps

`include "store_macros.svh"

module store_subsystem import store_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             valid_i,
    input  store_op_t        operation_i,
    input  logic [`XLEN-1:0] address_i,
    input  logic [`XLEN-1:0] data_i,
    input  tag_t             tag_i,
    output logic             done_o,
    output logic             idle_o,
    output tag_t             tag_o,
    output logic             exception_o,
    output exc_vector_t      exception_vector_o,
    input  logic [`XLEN-1:0] rd_address_i,
    output logic [`XLEN-1:0] rd_data_o
);

    mem_write_if   mem_bus ();
    instr_packet_t packet_in;
    instr_packet_t packet_out;

    assign packet_in = '{tag: tag_i, exception: 1'b0, exception_vector: NO_EXCEPTION};

    store_unit u_store_unit (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .valid_operation_i (valid_i),
        .operation_i       (operation_i),
        .store_address_i   (address_i),
        .store_data_i      (data_i),
        .instr_packet_i    (packet_in),
        .instr_packet_o    (packet_out),
        .idle_o            (idle_o),
        .done_o            (done_o),
        .mem               (mem_bus.requester)
    );

    data_memory_ctrl u_data_memory_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .mem          (mem_bus.responder),
        .rd_address_i (rd_address_i),
        .rd_data_o    (rd_data_o)
    );

    assign tag_o              = packet_out.tag;     // Valid only with done_o.
    assign exception_o        = packet_out.exception;
    assign exception_vector_o = packet_out.exception_vector;

endmodule : store_subsystem

// ==== source/store_unit.sv ====
`timescale 1ns/1ps

`include "store_macros.svh"

module store_unit import store_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             valid_operation_i,
    input  store_op_t        operation_i,
    input  logic [`XLEN-1:0] store_address_i,
    input  logic [`XLEN-1:0] store_data_i,
    input  instr_packet_t    instr_packet_i,
    output instr_packet_t    instr_packet_o,
    output logic             idle_o,
    output logic             done_o,
    mem_write_if.requester   mem
);

    typedef enum logic {IDLE, WAIT_MEM} store_fsm_t;

    logic cachable, bufferable, writable;

    memory_region_decoder region_decoder (
        .address_i    (store_address_i),
        .cachable_o   (cachable),
        .bufferable_o (bufferable),
        .writable_o   (writable)
    );

    //**************************************************************************
    // Registers
    //**************************************************************************

    store_fsm_t       state_crt, state_nxt;
    logic             done_crt, done_nxt;
    logic             write_crt, write_nxt;
    logic [`XLEN-1:0] address_crt, address_nxt;
    logic [`XLEN-1:0] data_crt, data_nxt;
    mem_width_t       width_crt, width_nxt;
    logic             cachable_crt, cachable_nxt;
    logic             bufferable_crt, bufferable_nxt;
    instr_packet_t    packet_crt, packet_nxt;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_crt <= IDLE;
            done_crt  <= 1'b0;
            write_crt <= 1'b0;
        end else begin
            state_crt <= state_nxt;
            done_crt  <= done_nxt;
            write_crt <= write_nxt;
        end
    end

    always_ff @(posedge clk_i) begin
        address_crt    <= address_nxt;
        data_crt       <= data_nxt;
        width_crt      <= width_nxt;
        cachable_crt   <= cachable_nxt;
        bufferable_crt <= bufferable_nxt;
        packet_crt     <= packet_nxt;
    end

    //**************************************************************************
    // FSM
    //**************************************************************************

    assign idle_o = (state_crt == IDLE) && !done_crt;    // Busy while reporting done.

    always_comb begin
        state_nxt      = state_crt;
        done_nxt       = 1'b0;
        write_nxt      = write_crt;
        address_nxt    = address_crt;
        data_nxt       = data_crt;
        width_nxt      = width_crt;
        cachable_nxt   = cachable_crt;
        bufferable_nxt = bufferable_crt;
        packet_nxt     = packet_crt;

        case (state_crt)
            IDLE: begin
                if (valid_operation_i && idle_o) begin
                    address_nxt    = store_address_i;
                    data_nxt       = store_data_i;
                    cachable_nxt   = cachable;
                    bufferable_nxt = bufferable;
                    packet_nxt     = instr_packet_i;

                    case (operation_i)
                        SB:      width_nxt = BYTE;
                        SH:      width_nxt = HALF_WORD;
                        default: width_nxt = WORD;
                    endcase

                    if (writable) begin
                        state_nxt = WAIT_MEM;
                        write_nxt = 1'b1;
                    end else begin
                        packet_nxt.exception        = 1'b1;   // Refused without a write.
                        packet_nxt.exception_vector = ILLEGAL_MEMORY_ACCESS;
                        done_nxt                    = 1'b1;
                    end
                end
            end

            WAIT_MEM: begin
                if (mem.store_done) begin
                    state_nxt = IDLE;
                    write_nxt = 1'b0;
                    done_nxt  = 1'b1;
                end
            end

            default: state_nxt = IDLE;
        endcase
    end

    assign done_o         = done_crt;
    assign instr_packet_o = packet_crt;

    assign mem.address    = address_crt;
    assign mem.data       = data_crt;
    assign mem.width      = width_crt;
    assign mem.cachable   = cachable_crt;
    assign mem.bufferable = bufferable_crt;
    assign mem.write      = write_crt;

    // The controller may sample the request on any cycle before it answers.
    a_request_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem.write && !mem.store_done |=> $stable(mem.address) && $stable(mem.data)
                                          && $stable(mem.width));

    a_done_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_o |=> !done_o);

endmodule : store_unit

// ==== store_subsystem.f ====
+incdir+source
source/store_pkg.sv
source/mem_write_if.sv
source/memory_region_decoder.sv
source/store_unit.sv
source/data_memory_ctrl.sv
source/store_subsystem.sv
testbench/store_checker.sv
testbench/store_subsystem_tb.sv

// ==== testbench/store_checker.sv ====
`timescale 1ns/1ps

module store_checker import store_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        valid_i,
    input  logic        idle_i,
    input  logic        done_i,
    input  tag_t        tag_i,
    input  logic        exception_i,
    input  exc_vector_t exception_vector_i,
    input  logic [31:0] rd_data_i,
    input  tag_t        req_tag_i,
    input  int          exp_cycles_i,
    input  logic        exp_exception_i,
    input  logic        rd_check_i,
    input  logic [31:0] exp_word_i,
    input  int          test_id_i,
    input  logic        test_end_i,
    input  logic        summary_i,
    output int          errors_o
);

    int          checks = 0;
    int          errors = 0;
    int          errors_before = 0;            // Error count when the current test began.
    int          accepted = 0;
    int          completed = 0;
    int          cycles = 0;
    logic        pending = 1'b0;
    logic        in_reset = 1'b0;
    int          want_cycles;
    tag_t        want_tag;
    logic        want_exception;
    exc_vector_t want_vector;

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset values";
            2:       return "word stores";
            3:       return "byte and halfword lanes";
            4:       return "region latency";
            5:       return "illegal stores";
            6:       return "ignored requests";
            default: return "unnamed";
        endcase
    endfunction

    task automatic compare(input logic [31:0] got, input logic [31:0] want,
                           input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    //**************************************************************************
    // Sampling on every rising edge
    //**************************************************************************

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending  = 1'b0;
            in_reset = 1'b1;
        end else begin
            if (in_reset) begin
                compare(32'(idle_i), 32'd1, "idle_o after reset");
                compare(32'(done_i), 32'd0, "done_o after reset");
                in_reset = 1'b0;
            end

            if (done_i) begin
                if (!pending) begin
                    errors++;
                    $display("Error at %0t ns: done_o rose without an accepted store", $time);
                end else begin
                    compare(32'(cycles + 1), 32'(want_cycles), "done_o cycle");
                    compare(32'(tag_i), 32'(want_tag), "tag_o");
                    compare(32'(exception_i), 32'(want_exception), "exception_o");
                    compare(32'(exception_vector_i), 32'(want_vector), "exception_vector_o");
                    completed++;
                end
                pending = 1'b0;
            end else if (pending) begin
                cycles++;
            end

            if (valid_i && idle_i) begin               // Cycle 0 of a new store.
                pending        = 1'b1;
                cycles         = 0;
                want_cycles    = exp_cycles_i;
                want_tag       = req_tag_i;
                want_exception = exp_exception_i;
                want_vector    = exp_exception_i ? ILLEGAL_MEMORY_ACCESS : NO_EXCEPTION;
                accepted++;
            end

            if (rd_check_i) begin
                compare(rd_data_i, exp_word_i, "rd_data_o");
            end

            if (test_end_i) begin
                $display("Test %0d (%s): %s, %0d errors", test_id_i, test_name(test_id_i),
                         (errors == errors_before) ? "ok" : "mismatch",
                         errors - errors_before);
                errors_before = errors;
            end

            if (summary_i) begin
                compare(32'(completed), 32'(accepted), "number of done_o pulses");
                $display("Checks %0d, errors %0d, stores accepted %0d, completed %0d",
                         checks, errors, accepted, completed);
            end
        end
    end

    assign errors_o = errors;

endmodule : store_checker

// ==== testbench/store_subsystem_tb.sv ====
`timescale 1ns/1ps

`include "store_macros.svh"

module store_subsystem_tb import store_pkg::*; ();

    logic             clk = 1'b0;
    logic             rst_n;
    logic             valid;
    store_op_t        operation;
    logic [`XLEN-1:0] address;
    logic [`XLEN-1:0] data;
    tag_t             tag;
    logic             done;
    logic             idle;
    tag_t             tag_out;
    logic             exception;
    exc_vector_t      exception_vector;
    logic [`XLEN-1:0] rd_address;
    logic [`XLEN-1:0] rd_data;

    int               exp_cycles;
    logic             exp_exception;
    logic             rd_check;
    logic [`XLEN-1:0] exp_word;
    int               test_id;
    logic             test_end;
    logic             summary;
    int               errors;

    integer           seed;
    logic [7:0]       model_mem [`MEM_BYTES];         // Byte image of the written memory.

    store_subsystem uut (
        .clk_i              (clk),
        .rst_n_i            (rst_n),
        .valid_i            (valid),
        .operation_i        (operation),
        .address_i          (address),
        .data_i             (data),
        .tag_i              (tag),
        .done_o             (done),
        .idle_o             (idle),
        .tag_o              (tag_out),
        .exception_o        (exception),
        .exception_vector_o (exception_vector),
        .rd_address_i       (rd_address),
        .rd_data_o          (rd_data)
    );

    store_checker u_checker (
        .clk_i              (clk),
        .rst_n_i            (rst_n),
        .valid_i            (valid),
        .idle_i             (idle),
        .done_i             (done),
        .tag_i              (tag_out),
        .exception_i        (exception),
        .exception_vector_i (exception_vector),
        .rd_data_i          (rd_data),
        .req_tag_i          (tag),
        .exp_cycles_i       (exp_cycles),
        .exp_exception_i    (exp_exception),
        .rd_check_i         (rd_check),
        .exp_word_i         (exp_word),
        .test_id_i          (test_id),
        .test_end_i         (test_end),
        .summary_i          (summary),
        .errors_o           (errors)
    );

    always #5 clk = ~clk;

    //**************************************************************************
    // Reference model
    //**************************************************************************

    function automatic logic is_writable(input logic [`XLEN-1:0] addr);
        return (addr >= `INT_TABLE_REGION_START) && (addr <= `IO_REGION_END);
    endfunction

    function automatic int expected_cycles(input logic [`XLEN-1:0] addr);
        if (!is_writable(addr)) return 1;
        if (addr <= `INT_TABLE_REGION_END) return 4;
        if (addr <= `CODE_REGION_END) return 3;
        return 6;                                        // IO region, uncached.
    endfunction

    task automatic update_model(input store_op_t op, input logic [`XLEN-1:0] addr,
                                input logic [`XLEN-1:0] value);
        logic [9:0] lo;
        case (op)
            SB: model_mem[addr[9:0]] = value[7:0];
            SH: begin
                lo = {addr[9:1], 1'b0};
                model_mem[lo]         = value[7:0];
                model_mem[lo + 10'd1] = value[15:8];
            end
            default: begin
                lo = {addr[9:2], 2'b00};
                model_mem[lo]         = value[7:0];
                model_mem[lo + 10'd1] = value[15:8];
                model_mem[lo + 10'd2] = value[23:16];
                model_mem[lo + 10'd3] = value[31:24];
            end
        endcase
    endtask

    function automatic logic [`XLEN-1:0] model_word(input logic [`XLEN-1:0] addr);
        logic [9:0] lo;
        lo = {addr[9:2], 2'b00};
        return {model_mem[lo + 10'd3], model_mem[lo + 10'd2],
                model_mem[lo + 10'd1], model_mem[lo]};
    endfunction

    //**************************************************************************
    // Stimulus helpers
    //**************************************************************************

    function automatic logic [`XLEN-1:0] region_address(input int region);
        case (region)
            0:       return `INT_TABLE_REGION_START + $unsigned($random(seed)) % 32'h40;
            1:       return `CODE_REGION_START + $unsigned($random(seed)) % 32'h1C0;
            default: return `IO_REGION_START + $unsigned($random(seed)) % 32'h100;
        endcase
    endfunction

    function automatic store_op_t random_op();
        case ($unsigned($random(seed)) % 32'd3)
            32'd0:   return SB;
            32'd1:   return SH;
            default: return SW;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run(input string why);
        $display("Run stopped at %0t ns: %s", $time, why);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic wait_for_idle();
        int n;
        n = 0;
        while (!idle && n < 20) begin
            next_cycle();
            n++;
        end
        if (!idle) begin
            abort_run("idle_o stayed low for 20 cycles");
        end
    endtask

    // With noisy set, valid_i is toggled with junk while the unit is busy.
    task automatic issue_store(input store_op_t op, input logic [`XLEN-1:0] addr,
                               input logic [`XLEN-1:0] value, input logic noisy);
        int n;
        wait_for_idle();
        valid         = 1'b1;
        operation     = op;
        address       = addr;
        data          = value;
        tag           = tag_t'($random(seed));
        exp_cycles    = expected_cycles(addr);
        exp_exception = !is_writable(addr);
        next_cycle();                                    // Accepted on this edge.
        valid = 1'b0;
        n = 0;
        while (!done && n < 20) begin
            if (noisy) begin
                valid   = 1'($random(seed));
                address = $random(seed);
                data    = $random(seed);
                tag     = tag_t'($random(seed));
            end
            next_cycle();
            n++;
        end
        valid = 1'b0;
        if (!done) begin
            abort_run("done_o did not rise within 20 cycles");
        end else if (is_writable(addr)) begin
            update_model(op, addr, value);
        end
    endtask

    task automatic check_read(input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] want);
        rd_address = addr;
        exp_word   = want;
        rd_check   = 1'b1;
        next_cycle();
        rd_check = 1'b0;
    endtask

    task automatic end_test(input int id);
        test_id  = id;
        test_end = 1'b1;
        next_cycle();
        test_end = 1'b0;
    endtask

    //**************************************************************************
    // Test sequence
    //**************************************************************************

    initial begin
        logic [`XLEN-1:0] addr;

        seed          = 32'hc80a_99ab;
        rst_n         = 1'b0;
        valid         = 1'b0;
        operation     = SW;
        address       = '0;
        data          = '0;
        tag           = '0;
        rd_address    = '0;
        exp_cycles    = 0;
        exp_exception = 1'b0;
        rd_check      = 1'b0;
        exp_word      = '0;
        test_id       = 0;
        test_end      = 1'b0;
        summary       = 1'b0;

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();                                    // Reset values are checked here.
        end_test(1);

        for (int i = 0; i < 12; i++) begin
            addr = region_address(i % 3);
            issue_store(SW, addr, $random(seed), 1'b0);
            check_read(addr, model_word(addr));
        end
        end_test(2);

        // Each word is filled first so every lane holds a known byte.
        for (int i = 0; i < 6; i++) begin
            addr = region_address(int'($unsigned($random(seed)) % 32'd3));
            issue_store(SW, addr, $random(seed), 1'b0);
            for (int j = 0; j < 3; j++) begin
                issue_store(($random(seed) % 2 == 0) ? SB : SH,
                            {addr[31:2], 2'($random(seed))}, $random(seed), 1'b0);
            end
            check_read(addr, model_word(addr));
        end
        end_test(3);

        for (int i = 0; i < 9; i++) begin
            addr = region_address(i / 3);
            issue_store(random_op(), addr, $random(seed), 1'b0);
            check_read(addr, model_word(addr));
        end
        end_test(4);

        // The boot region is never written, so the model word stays unknown.
        for (int i = 0; i < 4; i++) begin
            addr = `BOOT_REGION_START + $unsigned($random(seed)) % 32'h100;
            issue_store(random_op(), addr, $random(seed), 1'b0);
            check_read(addr, model_word(addr));
            issue_store(random_op(), $unsigned($random(seed)) | 32'h400, $random(seed), 1'b0);
        end
        end_test(5);

        for (int i = 0; i < 8; i++) begin
            addr = region_address(int'($unsigned($random(seed)) % 32'd3));
            issue_store(random_op(), addr, $random(seed), 1'b1);
            check_read(addr, model_word(addr));
        end
        end_test(6);

        summary = 1'b1;
        next_cycle();
        summary = 1'b0;
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : store_subsystem_tb
